/* project.f */
+incdir+verif
src/spi_pkg.sv
src/spi_core.sv
src/spi_sync.sv
src/spi_tx_fifo.sv
src/spi_fsm.sv
src/spi_registers.sv
src/spi.sv
verif/tb_clock_gen.sv
verif/tb_spi.sv

/* verif/tb_spi_tasks.svh */
//##########################################################################
// Directed tests for the SPI slave front end. Included inside tb_spi and
// uses its frame driver, register access tasks and check task.
//##########################################################################
`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

task automatic idle_status_test();
	logic [15:0] miso;
	check_value("o_interrupt", 16'(spi_interrupt), 16'h0000);
	check_value("o_spi_miso", 16'(spi_miso), 16'h0000); // Chip select is still high.
	@(posedge clk);
	hardware_error      <= 1'($random(seed));
	buffer_fill_warning <= 1'($random(seed));
	data_available      <= 1'($random(seed));
	@(posedge clk);
	spi_frame(16, {CMD_NOP, 12'h000}, miso);
	check_value("status word", miso, expected_status(1'b0));
endtask

task automatic mask_readback_test();
	logic [15:0] data;
	logic [15:0] value;
	data = 16'($random(seed));
	write_reg(REG_IRQ_MASK, data);
	read_reg(REG_IRQ_MASK, value);
	check_value("IRQ_MASK", value, {13'h0000, data[2:0]});
endtask

task automatic unknown_command_test();
	logic [15:0] miso;
	write_reg(REG_IRQ_MASK, 16'h0003);
	spi_frame(16, 16'h5000, miso);
	check_value("o_interrupt", 16'(spi_interrupt), 16'h0000); // CMD_IGN is masked off.
	spi_frame(16, {CMD_NOP, 12'h000}, miso);
	check_value("status word", miso, expected_status(1'b1));
	write_reg(REG_IRQ_MASK, 16'h0004);
	wait_interrupt(1'b1);
	write_reg(REG_IRQ_STAT, 16'h0004);
	wait_interrupt(1'b0);
	spi_frame(16, {CMD_NOP, 12'h000}, miso);
	check_value("status word", miso, expected_status(1'b0));
endtask

task automatic alignment_error_test();
	logic [15:0] miso;
	logic [15:0] value;
	spi_frame(9, 16'hffff, miso);
	read_reg(REG_IRQ_STAT, value);
	check_value("IRQ_STAT", value, 16'h0001);
	write_reg(REG_IRQ_STAT, 16'h0007);
	// A write whose data frame is cut short.
	spi_frame(16, {CMD_WRITE_REG, REG_IRQ_MASK}, miso);
	spi_frame(9, 16'h0000, miso);
	read_reg(REG_IRQ_STAT, value);
	check_value("IRQ_STAT", value, 16'h0003);
	check_value("o_interrupt", 16'(spi_interrupt), 16'h0000);
	read_reg(REG_IRQ_MASK, value);
	check_value("IRQ_MASK", value, 16'h0004);
	write_reg(REG_IRQ_STAT, 16'h0007);
endtask

task automatic timeout_and_queue_test();
	logic [15:0] miso;
	logic [15:0] value;
	spi_frame(16, {CMD_WRITE_REG, REG_IRQ_MASK}, miso);
	repeat (300) @(posedge clk);
	read_reg(REG_IRQ_STAT, value);
	check_value("IRQ_STAT", value, 16'h0002);
	read_reg(REG_IRQ_MASK, value);
	check_value("IRQ_MASK", value, 16'h0004);
	write_reg(REG_IRQ_STAT, 16'h0007);

	// Every frame start takes the queued word, so each read answers the one before it.
	spi_frame(16, {CMD_READ_REG, REG_IRQ_MASK}, miso);
	check_value("status word", miso, expected_status(1'b0));
	for (int i = 0; i < 4; i++) begin
		spi_frame(16, {CMD_READ_REG, REG_IRQ_MASK}, miso);
		check_value("queued IRQ_MASK", miso, 16'h0004);
	end
	spi_frame(16, {CMD_RESET, 12'h000}, miso);
	check_value("queued IRQ_MASK", miso, 16'h0004);
	spi_frame(16, {CMD_NOP, 12'h000}, miso);
	check_value("status word", miso, expected_status(1'b0)); // Queue never filled.
	check_value("o_interrupt", 16'(spi_interrupt), 16'h0000);
endtask

`endif

/* verif/tb_spi.sv */
`timescale 1ns/100ps
//##########################################################################
// Testbench top for the SPI slave front end. Acts as the SPI host in
// mode 0, runs the directed tests from tb_spi_tasks.svh and stops at the
// first mismatch.
//##########################################################################
module tb_spi import spi_pkg::*; ();

	logic   clk;
	logic   reset;
	logic   spi_sck             = 1'b0;
	logic   spi_csn             = 1'b1;
	logic   spi_mosi            = 1'b0;
	logic   spi_miso;
	logic   hardware_error      = 1'b0;
	logic   buffer_fill_warning = 1'b0;
	logic   data_available      = 1'b0;
	logic   spi_interrupt;
	integer seed                = 32'h5b9cc01b;

	tb_clock_gen tb_clock_gen_i (
		.o_clk   (clk  ),
		.o_reset (reset)
	);

	spi spi_i (
		.i_clk                 (clk                ),
		.i_reset               (reset              ),
		.i_spi_sck             (spi_sck            ),
		.i_spi_csn             (spi_csn            ),
		.i_spi_mosi            (spi_mosi           ),
		.o_spi_miso            (spi_miso           ),
		.i_hardware_error      (hardware_error     ),
		.i_buffer_fill_warning (buffer_fill_warning),
		.i_data_available      (data_available     ),
		.o_interrupt           (spi_interrupt      )
	);

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		if (actual !== expected)
			stop_with_failure($sformatf("error: %s is 0x%h, expected 0x%h",
				name, actual, expected));
	endtask

	// One host frame. SCK runs at 8 clock cycles per bit, MISO is read just before each rise.
	task automatic spi_frame(input int bits, input logic [15:0] tx, output logic [15:0] rx);
		logic [15:0] shift_out;
		shift_out = tx;
		rx        = '0;
		@(posedge clk);
		spi_csn  <= 1'b0;
		spi_mosi <= shift_out[15];
		for (int i = 0; i < bits; i++) begin
			repeat (4) @(posedge clk);
			rx = {rx[14:0], spi_miso};
			spi_sck <= 1'b1;
			repeat (4) @(posedge clk);
			shift_out = shift_out << 1;
			spi_sck  <= 1'b0;
			spi_mosi <= shift_out[15];
		end
		repeat (4) @(posedge clk);
		spi_csn  <= 1'b1;
		spi_mosi <= 1'b0;
		repeat (16) @(posedge clk); // Gap between frames.
	endtask

	task automatic write_reg(input logic [11:0] addr, input logic [15:0] data);
		logic [15:0] unused;
		spi_frame(16, {CMD_WRITE_REG, addr}, unused);
		spi_frame(16, data, unused);
	endtask

	// The answer to a read comes back in the following NOP frame.
	task automatic read_reg(input logic [11:0] addr, output logic [15:0] data);
		logic [15:0] unused;
		spi_frame(16, {CMD_READ_REG, addr}, unused);
		spi_frame(16, {CMD_NOP, 12'h000}, data);
	endtask

	task automatic wait_reset_release();
		for (int i = 0; i < 20; i++) begin
			@(posedge clk);
			if (!reset)
				return;
		end
		stop_with_failure("timeout waiting for reset to be released");
	endtask

	task automatic wait_interrupt(input logic level);
		for (int i = 0; i < 64; i++) begin
			if (spi_interrupt === level)
				return;
			@(posedge clk);
		end
		stop_with_failure($sformatf("timeout waiting for o_interrupt to become %0d", level));
	endtask

	// Status word as the host expects it: HE, PD, BF, SCE from bit 3 down.
	function automatic logic [15:0] expected_status(input logic sce);
		return {12'h000, hardware_error, data_available, buffer_fill_warning, sce};
	endfunction

	`include "tb_spi_tasks.svh"

	initial begin
		wait_reset_release();
		idle_status_test();
		mask_readback_test();
		unknown_command_test();
		alignment_error_test();
		timeout_and_queue_test();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/100ps
//##########################################################################
// Testbench clock and reset. Makes a 100 ns clock and holds the
// synchronous reset high for the first two rising edges.
//##########################################################################
module tb_clock_gen (
	output logic o_clk,
	output logic o_reset
);

	initial begin
		o_clk = 1'b0;
		forever #50 o_clk = ~o_clk;
	end

	initial begin
		o_reset = 1'b1;
		repeat (2) @(posedge o_clk);
		o_reset <= 1'b0;
	end

endmodule

/* src/spi.sv */
`timescale 1ns/100ps
//##########################################################################
// Top level of the SPI slave front end. Connects the SCK-domain core, the
// synchronizer, the response FIFO, the command FSM and the register map.
//##########################################################################
module spi import spi_pkg::*; (
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_spi_sck,
	input  logic i_spi_csn,
	input  logic i_spi_mosi,
	output logic o_spi_miso,
	input  logic i_hardware_error,
	input  logic i_buffer_fill_warning,
	input  logic i_data_available,
	output logic o_interrupt
);

	logic [SPI_WORD_WIDTH-1:0] tx_word;
	logic [SPI_WORD_WIDTH-1:0] rx_word_core;
	logic [SPI_WORD_WIDTH-1:0] rx_word;
	logic                      rx_toggle;
	logic                      taken_toggle;
	logic                      align_toggle;
	logic                      word_received;
	logic                      pop;
	logic                      alignment_error;
	logic [SPI_WORD_WIDTH-1:0] fifo_data;
	logic                      fifo_not_empty;
	logic                      fifo_full;
	logic                      push;
	logic [SPI_WORD_WIDTH-1:0] push_data;
	logic                      clear_fifo;
	logic                      reg_write;
	logic [SPI_ADDR_WIDTH-1:0] reg_addr;
	logic [SPI_WORD_WIDTH-1:0] reg_wdata;
	logic [SPI_WORD_WIDTH-1:0] reg_rdata;
	logic [SPI_WORD_WIDTH-1:0] status_word;
	logic                      cmd_ignored;
	logic                      cmd_incomplete;

	// Queued responses go first; an empty FIFO sends the live status.
	assign tx_word = fifo_not_empty ? fifo_data : status_word;

	spi_core spi_core_i (
		.i_spi_sck      (i_spi_sck     ),
		.i_spi_csn      (i_spi_csn     ),
		.i_spi_mosi     (i_spi_mosi    ),
		.i_tx_word      (tx_word       ),
		.i_tx_from_fifo (fifo_not_empty),
		.o_spi_miso     (o_spi_miso    ),
		.o_rx_word      (rx_word_core  ),
		.o_rx_toggle    (rx_toggle     ),
		.o_taken_toggle (taken_toggle  ),
		.o_align_toggle (align_toggle  )
	);

	spi_sync spi_sync_i (
		.i_clk             (i_clk          ),
		.i_reset           (i_reset        ),
		.i_rx_word         (rx_word_core   ),
		.i_rx_toggle       (rx_toggle      ),
		.i_taken_toggle    (taken_toggle   ),
		.i_align_toggle    (align_toggle   ),
		.o_rx_word         (rx_word        ),
		.o_word_received   (word_received  ),
		.o_pop             (pop            ),
		.o_alignment_error (alignment_error)
	);

	spi_tx_fifo spi_tx_fifo_i (
		.i_clk       (i_clk         ),
		.i_reset     (i_reset       ),
		.i_push      (push          ),
		.i_push_data (push_data     ),
		.i_pop       (pop           ),
		.i_clear     (clear_fifo    ),
		.o_data      (fifo_data     ),
		.o_not_empty (fifo_not_empty),
		.o_full      (fifo_full     )
	);

	spi_fsm spi_fsm_i (
		.i_clk             (i_clk          ),
		.i_reset           (i_reset        ),
		.i_word_received   (word_received  ),
		.i_rx_word         (rx_word        ),
		.i_alignment_error (alignment_error),
		.i_fifo_full       (fifo_full      ),
		.i_reg_rdata       (reg_rdata      ),
		.o_push            (push           ),
		.o_push_data       (push_data      ),
		.o_clear_fifo      (clear_fifo     ),
		.o_reg_write       (reg_write      ),
		.o_reg_addr        (reg_addr       ),
		.o_reg_wdata       (reg_wdata      ),
		.o_cmd_ignored     (cmd_ignored    ),
		.o_cmd_incomplete  (cmd_incomplete )
	);

	spi_registers spi_registers_i (
		.i_clk                 (i_clk                ),
		.i_reset               (i_reset              ),
		.i_reg_write           (reg_write            ),
		.i_reg_addr            (reg_addr             ),
		.i_reg_wdata           (reg_wdata            ),
		.i_alignment_error     (alignment_error      ),
		.i_cmd_ignored         (cmd_ignored          ),
		.i_cmd_incomplete      (cmd_incomplete       ),
		.i_hardware_error      (i_hardware_error     ),
		.i_buffer_fill_warning (i_buffer_fill_warning),
		.i_data_available      (i_data_available     ),
		.o_reg_rdata           (reg_rdata            ),
		.o_status_word         (status_word          ),
		.o_interrupt           (o_interrupt          )
	);

endmodule

/* src/spi_registers.sv */
`timescale 1ns/100ps
//##########################################################################
// SPI register map: sticky IRQ flags (write one to clear), IRQ mask and
// the live status word. Drives the interrupt line from flags and mask.
//##########################################################################
module spi_registers import spi_pkg::*; (
	input  logic                      i_clk,
	input  logic                      i_reset,
	input  logic                      i_reg_write,
	input  logic [SPI_ADDR_WIDTH-1:0] i_reg_addr,
	input  logic [SPI_WORD_WIDTH-1:0] i_reg_wdata,
	input  logic                      i_alignment_error,
	input  logic                      i_cmd_ignored,
	input  logic                      i_cmd_incomplete,
	input  logic                      i_hardware_error,
	input  logic                      i_buffer_fill_warning,
	input  logic                      i_data_available,
	output logic [SPI_WORD_WIDTH-1:0] o_reg_rdata,
	output logic [SPI_WORD_WIDTH-1:0] o_status_word,
	output logic                      o_interrupt
);

	logic [IRQ_WIDTH-1:0] irq_stat;
	logic [IRQ_WIDTH-1:0] irq_mask;
	logic [IRQ_WIDTH-1:0] irq_set;
	logic [IRQ_WIDTH-1:0] irq_clear;

	always_comb begin
		irq_set              = '0;
		irq_set[IRQ_ALI_ERR] = i_alignment_error;
		irq_set[IRQ_CMD_INC] = i_cmd_incomplete;
		irq_set[IRQ_CMD_IGN] = i_cmd_ignored;
	end

	assign irq_clear = (i_reg_write && i_reg_addr == REG_IRQ_STAT) ?
		i_reg_wdata[IRQ_WIDTH-1:0] : '0;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			irq_stat <= '0;
			irq_mask <= '0;
		end else begin
			irq_stat <= (irq_stat & ~irq_clear) | irq_set; // A new event beats the clear.
			if (i_reg_write && i_reg_addr == REG_IRQ_MASK)
				irq_mask <= i_reg_wdata[IRQ_WIDTH-1:0];
		end
	end

	always_comb begin
		o_status_word           = '0;
		o_status_word[STAT_SCE] = |irq_stat;
		o_status_word[STAT_BF]  = i_buffer_fill_warning;
		o_status_word[STAT_PD]  = i_data_available;
		o_status_word[STAT_HE]  = i_hardware_error;
	end

	always_comb begin
		case (i_reg_addr)
			REG_IRQ_STAT:    o_reg_rdata = SPI_WORD_WIDTH'(irq_stat);
			REG_IRQ_MASK:    o_reg_rdata = SPI_WORD_WIDTH'(irq_mask);
			REG_STATUS_WORD: o_reg_rdata = o_status_word;
			default:         o_reg_rdata = '0;
		endcase
	end

	assign o_interrupt = |(irq_stat & irq_mask);

endmodule

/* src/spi_fsm.sv */
`timescale 1ns/100ps
//##########################################################################
// Command decoder. Reads push the register value into the response FIFO,
// writes wait for a data word with a timeout, RESET flushes the FIFO.
//##########################################################################
module spi_fsm import spi_pkg::*; (
	input  logic                      i_clk,
	input  logic                      i_reset,
	input  logic                      i_word_received,
	input  spi_word_u                 i_rx_word,
	input  logic                      i_alignment_error,
	input  logic                      i_fifo_full,
	input  logic [SPI_WORD_WIDTH-1:0] i_reg_rdata,
	output logic                      o_push,
	output logic [SPI_WORD_WIDTH-1:0] o_push_data,
	output logic                      o_clear_fifo,
	output logic                      o_reg_write,
	output logic [SPI_ADDR_WIDTH-1:0] o_reg_addr,
	output logic [SPI_WORD_WIDTH-1:0] o_reg_wdata,
	output logic                      o_cmd_ignored,
	output logic                      o_cmd_incomplete
);

	logic                         state;
	logic [SPI_ADDR_WIDTH-1:0]    write_addr;
	logic [CMD_TIMEOUT_WIDTH-1:0] timeout_count;
	logic                         timed_out;

	// Reads use the command just received, writes the address kept from it.
	assign o_reg_addr  = o_reg_write ? write_addr : i_rx_word.cmd.address;
	assign o_reg_wdata = i_rx_word.data; // Still the data word during the write cycle.
	assign timed_out   = (timeout_count == CMD_TIMEOUT_WIDTH'(CMD_TIMEOUT_CYCLES - 1));

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state            <= FSM_IDLE;
			timeout_count    <= '0;
			o_push           <= 1'b0;
			o_clear_fifo     <= 1'b0;
			o_reg_write      <= 1'b0;
			o_cmd_ignored    <= 1'b0;
			o_cmd_incomplete <= 1'b0;
		end else begin
			o_push           <= 1'b0;
			o_clear_fifo     <= 1'b0;
			o_reg_write      <= 1'b0;
			o_cmd_ignored    <= 1'b0;
			o_cmd_incomplete <= 1'b0;
			case (state)
				FSM_IDLE: begin
					if (i_word_received) begin
						case (i_rx_word.cmd.command)
							CMD_NOP: ;
							CMD_READ_REG: begin
								if (i_fifo_full)
									o_cmd_ignored <= 1'b1;
								else
									o_push <= 1'b1;
							end
							CMD_WRITE_REG: begin
								state         <= FSM_WAIT_DATA;
								timeout_count <= '0;
							end
							CMD_RESET: o_clear_fifo <= 1'b1;
							default:   o_cmd_ignored <= 1'b1;
						endcase
					end
				end
				FSM_WAIT_DATA: begin
					timeout_count <= timeout_count + 1'b1;
					if (i_alignment_error || timed_out) begin
						o_cmd_incomplete <= 1'b1;
						state            <= FSM_IDLE;
					end else if (i_word_received) begin
						o_reg_write <= 1'b1;
						state       <= FSM_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == FSM_IDLE && i_word_received) begin
			write_addr  <= i_rx_word.cmd.address;
			o_push_data <= i_reg_rdata;
		end
	end

endmodule

/* src/spi_tx_fifo.sv */
`timescale 1ns/100ps
//##########################################################################
// Response word FIFO. The FSM pushes read results; the core takes the
// head at each frame start and the pop follows through the synchronizer.
//##########################################################################
module spi_tx_fifo import spi_pkg::*; (
	input  logic                      i_clk,
	input  logic                      i_reset,
	input  logic                      i_push,
	input  logic [SPI_WORD_WIDTH-1:0] i_push_data,
	input  logic                      i_pop,
	input  logic                      i_clear,
	output logic [SPI_WORD_WIDTH-1:0] o_data,
	output logic                      o_not_empty,
	output logic                      o_full
);

	logic [SPI_WORD_WIDTH-1:0]      mem [TX_FIFO_DEPTH];
	logic [TX_FIFO_PTR_WIDTH-1:0]   wr_ptr;
	logic [TX_FIFO_PTR_WIDTH-1:0]   rd_ptr;
	logic [TX_FIFO_COUNT_WIDTH-1:0] count;
	logic                           do_push;
	logic                           do_pop;

	assign do_push = i_push && !o_full; // A push into a full FIFO is lost.
	assign do_pop  = i_pop && o_not_empty;

	always_ff @(posedge i_clk) begin
		if (i_reset || i_clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (do_push)
			mem[wr_ptr] <= i_push_data;
	end

	assign o_data      = mem[rd_ptr];
	assign o_not_empty = (count != '0);
	assign o_full      = (count == TX_FIFO_COUNT_WIDTH'(TX_FIFO_DEPTH));

	// The core only takes a FIFO word when it saw one at chip select fall.
	a_no_pop_empty: assert property (@(posedge i_clk) disable iff (i_reset)
		i_pop |-> o_not_empty);

endmodule

/* src/spi_sync.sv */
`timescale 1ns/100ps
//##########################################################################
// Brings the core's toggle events into the i_clk domain as one-cycle
// pulses and captures the received word alongside the receive pulse.
//##########################################################################
module spi_sync import spi_pkg::*; (
	input  logic                      i_clk,
	input  logic                      i_reset,
	input  logic [SPI_WORD_WIDTH-1:0] i_rx_word,
	input  logic                      i_rx_toggle,
	input  logic                      i_taken_toggle,
	input  logic                      i_align_toggle,
	output logic [SPI_WORD_WIDTH-1:0] o_rx_word,
	output logic                      o_word_received,
	output logic                      o_pop,
	output logic                      o_alignment_error
);

	// Bit 0 receive, bit 1 FIFO word taken, bit 2 misaligned frame.
	logic [2:0] toggles;
	logic [2:0] sync_1;
	logic [2:0] sync_2;
	logic [2:0] sync_last;
	logic [2:0] pulse;

	assign toggles = {i_align_toggle, i_taken_toggle, i_rx_toggle};

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			sync_1    <= '0;
			sync_2    <= '0;
			sync_last <= '0;
			pulse     <= '0;
		end else begin
			sync_1    <= toggles;
			sync_2    <= sync_1;
			sync_last <= sync_2;
			pulse     <= sync_2 ^ sync_last; // Any change of a toggle is one event.
		end
	end

	// The core word is stable for a whole frame after its toggle flips.
	always_ff @(posedge i_clk) begin
		if (sync_2[0] != sync_last[0])
			o_rx_word <= i_rx_word;
	end

	assign o_word_received   = pulse[0];
	assign o_pop             = pulse[1];
	assign o_alignment_error = pulse[2];

	// Frames are far apart compared to i_clk, so events never merge.
	for (genvar i = 0; i < 3; i++) begin : g_pulse_check
		a_single_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
			pulse[i] |=> !pulse[i]);
	end

endmodule

/* src/spi_core.sv */
`timescale 1ns/100ps
//##########################################################################
// SCK domain of the SPI slave, mode 0, MSB first. Shifts in command words,
// shifts out the word latched at chip select fall, and reports frame
// events to the system clock domain as toggles.
//##########################################################################
module spi_core import spi_pkg::*; (
	input  logic                      i_spi_sck,
	input  logic                      i_spi_csn,
	input  logic                      i_spi_mosi,
	input  logic [SPI_WORD_WIDTH-1:0] i_tx_word,
	input  logic                      i_tx_from_fifo,
	output logic                      o_spi_miso,
	output logic [SPI_WORD_WIDTH-1:0] o_rx_word,
	output logic                      o_rx_toggle,
	output logic                      o_taken_toggle,
	output logic                      o_align_toggle
);

	logic [SPI_COUNT_WIDTH-1:0] bit_count = '0;
	logic [SPI_WORD_WIDTH-2:0]  rx_shift;
	logic [SPI_WORD_WIDTH-1:0]  tx_word;
	logic [SPI_INDEX_WIDTH-1:0] tx_bit    = '0;

	// Power-up values; the toggles only ever flip afterwards.
	logic rx_toggle    = 1'b0;
	logic taken_toggle = 1'b0;
	logic align_toggle = 1'b0;

	assign o_rx_toggle    = rx_toggle;
	assign o_taken_toggle = taken_toggle;
	assign o_align_toggle = align_toggle;

	// Rising edges of the frame, held at zero while chip select is high.
	// The count stops one past a full frame, so extra edges stay visible.
	always_ff @(posedge i_spi_sck or posedge i_spi_csn) begin
		if (i_spi_csn)
			bit_count <= '0;
		else if (bit_count != SPI_COUNT_WIDTH'(SPI_WORD_WIDTH + 1))
			bit_count <= bit_count + 1'b1;
	end

	always_ff @(posedge i_spi_sck) begin
		rx_shift <= {rx_shift[SPI_WORD_WIDTH-3:0], i_spi_mosi};
		if (bit_count == SPI_COUNT_WIDTH'(SPI_WORD_WIDTH - 1)) begin
			o_rx_word <= {rx_shift, i_spi_mosi}; // Held until the next full word.
			rx_toggle <= ~rx_toggle;
		end
	end

	always_ff @(negedge i_spi_csn) begin
		tx_word <= i_tx_word;
		if (i_tx_from_fifo)
			taken_toggle <= ~taken_toggle;
	end

	// Falling edges move MISO to the next lower bit.
	always_ff @(negedge i_spi_sck or posedge i_spi_csn) begin
		if (i_spi_csn)
			tx_bit <= '0;
		else if (tx_bit != '1)
			tx_bit <= tx_bit + 1'b1;
	end

	assign o_spi_miso = i_spi_csn ? 1'b0 : tx_word[~tx_bit]; // ~tx_bit selects MSB first.

	// The counter is sampled here before its clear by the same edge takes effect.
	always_ff @(posedge i_spi_csn) begin
		if (bit_count != '0 && bit_count != SPI_COUNT_WIDTH'(SPI_WORD_WIDTH))
			align_toggle <= ~align_toggle;
	end

	// MISO sits on the same bit as the rising edge that samples MOSI.
	a_edges_paired: assert property (@(posedge i_spi_sck)
		(bit_count < SPI_COUNT_WIDTH'(SPI_WORD_WIDTH)) |->
		(tx_bit == bit_count[SPI_INDEX_WIDTH-1:0]));

endmodule

/* src/spi_pkg.sv */
//##########################################################################
// Shared definitions for the SPI slave front end: frame format, command
// codes, register map, IRQ and status bit positions, FIFO and timeout
// sizes. Every SPI module imports this package.
//##########################################################################
package spi_pkg;

	localparam int SPI_WORD_WIDTH  = 16;
	localparam int SPI_INDEX_WIDTH = $clog2(SPI_WORD_WIDTH);
	localparam int SPI_COUNT_WIDTH = SPI_INDEX_WIDTH + 1; // Counts up to one past a full frame.
	localparam int SPI_CMD_WIDTH   = 4;
	localparam int SPI_ADDR_WIDTH  = 12;

	typedef enum logic [SPI_CMD_WIDTH-1:0] {
		CMD_NOP       = 4'd0,
		CMD_READ_REG  = 4'd1,
		CMD_WRITE_REG = 4'd2,
		CMD_RESET     = 4'd15
	} spi_command_e;

	// A received word is a command, or the data word following CMD_WRITE_REG.
	typedef union packed {
		struct packed {
			spi_command_e              command;
			logic [SPI_ADDR_WIDTH-1:0] address;
		} cmd;
		logic [SPI_WORD_WIDTH-1:0] data;
	} spi_word_u;

	localparam logic [SPI_ADDR_WIDTH-1:0] REG_IRQ_STAT    = 12'd0;
	localparam logic [SPI_ADDR_WIDTH-1:0] REG_IRQ_MASK    = 12'd1;
	localparam logic [SPI_ADDR_WIDTH-1:0] REG_STATUS_WORD = 12'd2;

	localparam int IRQ_ALI_ERR = 0;
	localparam int IRQ_CMD_INC = 1;
	localparam int IRQ_CMD_IGN = 2;
	localparam int IRQ_WIDTH   = 3;

	localparam int STAT_SCE = 0;
	localparam int STAT_BF  = 1;
	localparam int STAT_PD  = 2;
	localparam int STAT_HE  = 3;

	localparam int TX_FIFO_DEPTH       = 4;
	localparam int TX_FIFO_PTR_WIDTH   = $clog2(TX_FIFO_DEPTH);
	localparam int TX_FIFO_COUNT_WIDTH = $clog2(TX_FIFO_DEPTH + 1);

	localparam int CMD_TIMEOUT_CYCLES = 256;
	localparam int CMD_TIMEOUT_WIDTH  = $clog2(CMD_TIMEOUT_CYCLES);

	localparam logic FSM_IDLE      = 1'b0;
	localparam logic FSM_WAIT_DATA = 1'b1;

endpackage
